// ==== source/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN        32
`define REG_COUNT   32
`define REG_IDX_W   5
`define MEM_ADDR_W  16
`define STACK_REG   2
`define STACK_START 32'h0000_7ffc
`define PC_INC      32'd4

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

// Branch conditions
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// ALU functions, shared by OP and OP_IMM
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`endif

// ==== source/rv_pkg.sv ====
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  // One instruction walks T0 up to at most T4
  typedef enum logic [2:0] {
    stage_t0,
    stage_t1,
    stage_t2,
    stage_t3,
    stage_t4
  } stage_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  typedef struct packed {
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  funct7_b30;  // Selects sub and sra
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`XLEN-1:0]      imm_i;
    logic [`XLEN-1:0]      imm_s;
    logic [`XLEN-1:0]      imm_b;
    logic [`XLEN-1:0]      imm_u;
    logic [`XLEN-1:0]      imm_j;
  } decoded_instr_t;

  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;  // Byte address
    logic [`XLEN-1:0]       wdata;
    logic                   re;
    logic                   we;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== source/instr_decode.sv ====
`default_nettype none

`include "rv_consts.svh"

module instr_decode (
  input  logic [`XLEN-1:0]       ir,
  output rv_pkg::decoded_instr_t dec
);
  import rv_pkg::*;

  logic sign;

  assign sign = ir[31];

  always_comb begin
    dec.opcode     = ir[6:0];
    dec.rd         = ir[11:7];
    dec.funct3     = ir[14:12];
    dec.rs1        = ir[19:15];
    dec.rs2        = ir[24:20];
    dec.funct7_b30 = ir[30];

    dec.imm_i = {{20{sign}}, ir[31:20]};
    dec.imm_s = {{20{sign}}, ir[31:25], ir[11:7]};

    // Offsets in halfwords, bit 0 always zero
    dec.imm_b = {{20{sign}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    dec.imm_j = {{12{sign}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    dec.imm_u = {ir[31:12], 12'b0};
  end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none

`include "rv_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  we,
  input  logic [`REG_IDX_W-1:0] rs1_idx,
  input  logic [`REG_IDX_W-1:0] rs2_idx,
  input  logic [`REG_IDX_W-1:0] rd_idx,
  input  logic [`XLEN-1:0]      wdata,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= (i == `STACK_REG) ? `STACK_START : '0;  // sp starts at top of RAM
      end
    end else if (we && rd_idx != '0) begin
      regs[rd_idx] <= wdata;
    end
  end

  // x0 hardwired
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`default_nettype none

`include "rv_consts.svh"

module alu (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  rv_pkg::alu_op_e  op,
  output logic [`XLEN-1:0] res,
  output logic             eq,
  output logic             ge,
  output logic             geu
);
  import rv_pkg::*;

  logic [`REG_IDX_W-1:0] shamt;

  assign shamt = b[`REG_IDX_W-1:0];

  // Compare flags are independent of op, branches rely on that
  assign eq  = (a == b);
  assign ge  = ($signed(a) >= $signed(b));
  assign geu = (a >= b);

  always_comb begin
    case (op)
      alu_add:  res = a + b;
      alu_sub:  res = a - b;
      alu_slt:  res = {{(`XLEN-1){1'b0}}, ~ge};
      alu_sltu: res = {{(`XLEN-1){1'b0}}, ~geu};
      alu_xor:  res = a ^ b;
      alu_or:   res = a | b;
      alu_and:  res = a & b;
      alu_sll:  res = a << shamt;
      alu_srl:  res = a >> shamt;
      alu_sra:  res = $signed(a) >>> shamt;
      default:  res = a + b;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/cpu_control.sv ====
`default_nettype none

`include "rv_consts.svh"

module cpu_control (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [`XLEN-1:0]       mem_rdata,
  input  rv_pkg::decoded_instr_t dec,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  input  logic [`XLEN-1:0]       alu_res,
  input  logic                   alu_eq,
  input  logic                   alu_ge,
  input  logic                   alu_geu,
  output logic [`XLEN-1:0]       ir,
  output logic [`REG_IDX_W-1:0]  rs1_idx,
  output logic [`REG_IDX_W-1:0]  rs2_idx,
  output logic [`REG_IDX_W-1:0]  rd_idx,
  output logic [`XLEN-1:0]       rd_wdata,
  output logic                   rd_we,
  output logic [`XLEN-1:0]       alu_a,
  output logic [`XLEN-1:0]       alu_b,
  output rv_pkg::alu_op_e        alu_op,
  output rv_pkg::mem_req_t       mem_req
);
  import rv_pkg::*;

  stage_e           stage;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] br_target;
  logic [`XLEN-1:0] jalr_target;
  logic             take_branch;
  alu_op_e          ex_op;
  logic [`XLEN-1:0] ex_b;
  logic             fetch_now;
  logic [`XLEN-1:0] fetch_pc;

  // Register reads follow ir directly, valid from T1 on
  assign rs1_idx = dec.rs1;
  assign rs2_idx = dec.rs2;

  assign jalr_target = {alu_res[`XLEN-1:1], 1'b0};

  always_comb begin
    case (dec.funct3)
      `F3_BEQ:  take_branch = alu_eq;
      `F3_BNE:  take_branch = !alu_eq;
      `F3_BLT:  take_branch = !alu_ge;
      `F3_BGE:  take_branch = alu_ge;
      `F3_BLTU: take_branch = !alu_geu;
      `F3_BGEU: take_branch = alu_geu;
      default:  take_branch = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      `F3_ADD:  ex_op = (dec.opcode == `OPC_OP && dec.funct7_b30) ? alu_sub : alu_add;
      `F3_SLL:  ex_op = alu_sll;
      `F3_SLT:  ex_op = alu_slt;
      `F3_SLTU: ex_op = alu_sltu;
      `F3_XOR:  ex_op = alu_xor;
      `F3_SR:   ex_op = dec.funct7_b30 ? alu_sra : alu_srl;
      `F3_OR:   ex_op = alu_or;
      default:  ex_op = alu_and;
    endcase
  end

  always_comb begin
    if (dec.opcode == `OPC_OP) begin
      ex_b = rs2_data;
    end else if (dec.funct3 == `F3_SLL || dec.funct3 == `F3_SR) begin
      ex_b = {{(`XLEN-`REG_IDX_W){1'b0}}, dec.rs2};  // shamt sits in the rs2 field
    end else begin
      ex_b = dec.imm_i;
    end
  end

  // Last stage of each instruction and the pc it continues at
  always_comb begin
    fetch_now = 1'b0;
    fetch_pc  = pc;
    case (stage)
      stage_t0: fetch_now = 1'b0;
      stage_t1: begin
        case (dec.opcode)
          `OPC_OP, `OPC_OP_IMM, `OPC_BRANCH, `OPC_LOAD,
          `OPC_STORE, `OPC_AUIPC, `OPC_JAL, `OPC_JALR: fetch_now = 1'b0;
          default: begin  // LUI, and unknown opcodes skip ahead
            fetch_now = 1'b1;
            fetch_pc  = alu_res;
          end
        endcase
      end
      stage_t2: begin
        if (dec.opcode == `OPC_AUIPC) begin
          fetch_now = 1'b1;
        end else if (dec.opcode == `OPC_JAL) begin
          fetch_now = 1'b1;
          fetch_pc  = alu_res;
        end
      end
      stage_t3: begin
        if (dec.opcode == `OPC_OP || dec.opcode == `OPC_OP_IMM) begin
          fetch_now = 1'b1;
        end else if (dec.opcode == `OPC_BRANCH) begin
          fetch_now = 1'b1;
          fetch_pc  = take_branch ? br_target : pc;
        end else if (dec.opcode == `OPC_JALR) begin
          fetch_now = 1'b1;
          fetch_pc  = jalr_target;
        end
      end
      default: fetch_now = 1'b1;  // T4 always ends
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      stage        <= stage_t0;
      pc           <= '0;
      rd_we        <= 1'b0;
      mem_req.re   <= 1'b1;
      mem_req.we   <= 1'b0;
      mem_req.addr <= '0;
    end else begin
      case (stage)
        stage_t0: begin
          ir         <= mem_rdata;
          alu_a      <= pc;
          alu_b      <= `PC_INC;
          alu_op     <= alu_add;
          rd_we      <= 1'b0;
          mem_req.re <= 1'b0;
          stage      <= stage_t1;
        end

        stage_t1: begin
          stage <= stage_t2;
          case (dec.opcode)
            `OPC_OP, `OPC_OP_IMM, `OPC_LOAD, `OPC_STORE: pc <= alu_res;
            `OPC_BRANCH: begin
              pc    <= alu_res;
              alu_b <= dec.imm_b;  // alu_a still holds the old pc
            end
            `OPC_AUIPC: begin
              pc    <= alu_res;
              alu_b <= dec.imm_u;
            end
            `OPC_LUI: begin
              rd_we    <= 1'b1;
              rd_idx   <= dec.rd;
              rd_wdata <= dec.imm_u;
            end
            `OPC_JAL: begin
              rd_we    <= 1'b1;
              rd_idx   <= dec.rd;
              rd_wdata <= alu_res;
              alu_b    <= dec.imm_j;
            end
            `OPC_JALR: begin
              rd_we    <= 1'b1;
              rd_idx   <= dec.rd;
              rd_wdata <= alu_res;
            end
            default: rd_we <= 1'b0;
          endcase
        end

        stage_t2: begin
          stage <= stage_t3;
          rd_we <= 1'b0;
          case (dec.opcode)
            `OPC_OP, `OPC_OP_IMM: begin
              alu_a  <= rs1_data;
              alu_b  <= ex_b;
              alu_op <= ex_op;
            end
            `OPC_BRANCH: begin
              br_target <= alu_res;
              alu_a     <= rs1_data;
              alu_b     <= rs2_data;
            end
            `OPC_LOAD, `OPC_JALR: begin
              alu_a <= rs1_data;
              alu_b <= dec.imm_i;
            end
            `OPC_STORE: begin
              alu_a <= rs1_data;
              alu_b <= dec.imm_s;
            end
            `OPC_AUIPC: begin
              rd_we    <= 1'b1;
              rd_idx   <= dec.rd;
              rd_wdata <= alu_res;
            end
            default: stage <= stage_t3;
          endcase
        end

        stage_t3: begin
          stage <= stage_t4;
          case (dec.opcode)
            `OPC_OP, `OPC_OP_IMM: begin
              rd_we    <= 1'b1;
              rd_idx   <= dec.rd;
              rd_wdata <= alu_res;
            end
            `OPC_LOAD: begin
              mem_req.re   <= 1'b1;
              mem_req.addr <= alu_res[`MEM_ADDR_W-1:0];
            end
            `OPC_STORE: begin
              mem_req.we    <= 1'b1;
              mem_req.addr  <= alu_res[`MEM_ADDR_W-1:0];
              mem_req.wdata <= rs2_data;
            end
            default: rd_we <= 1'b0;
          endcase
        end

        default: begin
          if (dec.opcode == `OPC_LOAD) begin
            rd_we    <= 1'b1;
            rd_idx   <= dec.rd;
            rd_wdata <= mem_rdata;  // Word read in T3
          end
        end
      endcase

      if (fetch_now) begin
        pc           <= fetch_pc;
        mem_req.re   <= 1'b1;
        mem_req.we   <= 1'b0;
        mem_req.addr <= fetch_pc[`MEM_ADDR_W-1:0];
        stage        <= stage_t0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`default_nettype none

`include "rv_consts.svh"

module cpu_top (
  input  logic               clk,
  input  logic               rstn,
  input  logic [`XLEN-1:0]   mem_rdata,
  output rv_pkg::mem_req_t   mem_req
);
  import rv_pkg::*;

  logic [`XLEN-1:0]      ir;
  decoded_instr_t        dec;
  logic [`REG_IDX_W-1:0] rs1_idx;
  logic [`REG_IDX_W-1:0] rs2_idx;
  logic [`REG_IDX_W-1:0] rd_idx;
  logic [`XLEN-1:0]      rd_wdata;
  logic                  rd_we;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  logic [`XLEN-1:0]      alu_a;
  logic [`XLEN-1:0]      alu_b;
  alu_op_e               alu_op;
  logic [`XLEN-1:0]      alu_res;
  logic                  alu_eq;
  logic                  alu_ge;
  logic                  alu_geu;

  cpu_control ctrl0 (
    .clk       (clk),
    .rstn      (rstn),
    .mem_rdata (mem_rdata),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .alu_res   (alu_res),
    .alu_eq    (alu_eq),
    .alu_ge    (alu_ge),
    .alu_geu   (alu_geu),
    .ir        (ir),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rd_idx    (rd_idx),
    .rd_wdata  (rd_wdata),
    .rd_we     (rd_we),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_op    (alu_op),
    .mem_req   (mem_req)
  );

  instr_decode dec0 (
    .ir  (ir),
    .dec (dec)
  );

  reg_file regs0 (
    .clk      (clk),
    .rstn     (rstn),
    .we       (rd_we),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rd_idx   (rd_idx),
    .wdata    (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu0 (
    .a   (alu_a),
    .b   (alu_b),
    .op  (alu_op),
    .res (alu_res),
    .eq  (alu_eq),
    .ge  (alu_ge),
    .geu (alu_geu)
  );

endmodule

`default_nettype wire

// ==== tests/cpu_tb_sva.sv ====
`default_nettype none

`include "rv_consts.svh"

module cpu_tb_sva (
  input logic                  clk,
  input logic                  rstn,
  input rv_pkg::mem_req_t      mem_req,
  input logic [`REG_IDX_W-1:0] rs1_idx,
  input logic [`REG_IDX_W-1:0] rs2_idx,
  input logic [`XLEN-1:0]      rs1_data,
  input logic [`XLEN-1:0]      rs2_data
);
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  int fail_count = 0;

  assert property (@(posedge clk) disable iff (rstn) !(mem_req.re && mem_req.we))
    else begin
      $error("Read and write strobes high together");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rstn) mem_req.we |-> mem_req.addr[1:0] == 2'b00)
    else begin
      $error("Store to an unaligned address");
      fail_count++;
    end

  // x0 reads back zero on both ports
  assert property (@(posedge clk) disable iff (rstn)
                   (rs1_idx != '0 || rs1_data == '0) && (rs2_idx != '0 || rs2_data == '0))
    else begin
      $error("Register x0 read nonzero");
      fail_count++;
    end

  assert property (@(posedge clk) rstn |=> !mem_req.we)
    else begin
      $error("Write strobe high during reset");
      fail_count++;
    end

endmodule

bind cpu_top cpu_tb_sva sva0 (
  .clk      (clk),
  .rstn     (rstn),
  .mem_req  (mem_req),
  .rs1_idx  (rs1_idx),
  .rs2_idx  (rs2_idx),
  .rs1_data (rs1_data),
  .rs2_data (rs2_data)
);

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`default_nettype none

`include "rv_consts.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  localparam int MEM_WORDS  = 16384;
  localparam int PAT_WORDS  = 512;
  localparam int PROG_WORDS = 'h100;
  localparam int LABEL_BASE = 'h100;  // Pairs of test number and store count
  localparam int EXP_BASE   = 'h120;  // Triples of test number, address, value
  localparam int NUM_TESTS  = 6;
  localparam int STORE_TIMEOUT = 2000;
  localparam int END_TIMEOUT   = 20000;

  logic             clk;
  logic             rstn;
  logic [`XLEN-1:0] mem_rdata;
  mem_req_t         mem_req;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] pat [PAT_WORDS];
  int          errors;
  int          tests_passed;
  int          tests_failed;

  cpu_top dut0 (
    .clk       (clk),
    .rstn      (rstn),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req)
  );

  always #4 clk = ~clk;

  // Memory model, word answers one cycle after the read strobe
  always @(posedge clk) begin
    #1;
    if (mem_req.re) mem_rdata = mem[mem_req.addr[15:2]];
    if (mem_req.we) mem[mem_req.addr[15:2]] = mem_req.wdata;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  // Next store into the result area, or a timeout
  task automatic wait_result_store(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < STORE_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
      if (mem_req.we && mem_req.addr >= 16'h8000) seen = 1'b1;
    end
  endtask

  task automatic wait_end_marker(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < END_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
      if (mem_req.we && mem_req.addr == 16'hfff0) begin
        seen = 1'b1;
      end else if (mem_req.we && mem_req.addr >= 16'h8000) begin
        $display("Unexpected store to %h after the last expected result", mem_req.addr);
        errors++;
      end
    end
  endtask

  initial begin
    int  rec;
    int  test_id;
    int  count;
    int  errors_before;
    bit  seen;
    bit  aborted;
    clk       = 1'b0;
    rstn      = 1'b1;
    mem_rdata = '0;
    errors    = 0;
    tests_passed = 0;
    tests_failed = 0;
    aborted   = 1'b0;

    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[15:0], 16'ha5a5 ^ i[15:0]};
    end
    $readmemh("tests/cpu_patterns.txt", pat);
    for (int i = 0; i < PROG_WORDS; i++) begin
      if (!$isunknown(pat[i])) mem[i] = pat[i];
    end

    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b0;
    check_value("mem_req.re", {31'b0, mem_req.re}, 32'd1);  // Fetch of word 0 pending
    check_value("mem_req.addr", {16'b0, mem_req.addr}, 32'h0);

    rec = EXP_BASE;
    for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
      test_id       = pat[LABEL_BASE + 2 * t];
      count         = pat[LABEL_BASE + 2 * t + 1];
      errors_before = errors;
      for (int k = 0; k < count && !aborted; k++) begin
        wait_result_store(seen);
        if (!seen) begin
          $display("Test %0d: no store within %0d cycles", test_id, STORE_TIMEOUT);
          errors++;
          aborted = 1'b1;
        end else if (mem_req.addr == 16'hfff0) begin
          $display("Test %0d: program ended before all expected stores", test_id);
          errors++;
          aborted = 1'b1;
        end else begin
          check_value("mem_req.addr", {16'b0, mem_req.addr}, pat[rec + 1]);
          check_value("mem_req.wdata", mem_req.wdata, pat[rec + 2]);
          rec += 3;
        end
      end
      if (errors == errors_before) begin
        $display("Test %0d passed", test_id);
        tests_passed++;
      end else begin
        $display("Test %0d failed", test_id);
        tests_failed++;
      end
    end

    if (!aborted) begin
      wait_end_marker(seen);
      if (!seen) begin
        $display("Timed out after %0d cycles waiting for the end of the program", END_TIMEOUT);
        errors++;
      end
    end

    if (dut0.sva0.fail_count != 0) begin
      $display("%0d assertion failures in the bound checker", dut0.sva0.fail_count);
      errors += dut0.sva0.fail_count;
    end

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/cpu_patterns.txt ====
// @000 program words; @100 test number and store count; @120 test, address, value
// Results go to 0x8000 upward, a store to 0xFFF0 ends the program
@000
00008FB7 002FA023 FEC00293 00300313
006283B3 007FA223 406283B3 007FA423 0062A3B3 007FA623 0062B3B3 007FA823
0062C3B3 007FAA23 0062E3B3 007FAC23 0062F3B3 007FAE23 006293B3 027FA023
0062D3B3 027FA223 4062D3B3 027FA423
06428393 027FA623 00429393 027FA823 4022D393 027FAA23 123453B7 027FAC23
00001397 027FAE23
10000393 00528463 20000393 047FA023 10100393 00628463 20100393 047FA223
10200393 00629463 20200393 047FA423 10300393 00529463 20300393 047FA623
10400393 0062C463 20400393 047FA823 10500393 00534463 20500393 047FAA23
10600393 00535463 20600393 047FAC23 10700393 0062D463 20700393 047FAE23
10800393 00536463 20800393 067FA023 10900393 0062E463 20900393 067FA223
10A00393 0062F463 20A00393 067FA423 10B00393 00537463 20B00393 067FA623
30100393 0080046F 7FF00393 068FA823 067FAA23 16D00493 30200393 00048567
7FF00393 06AFAC23 067FAE23
FE512E23 FE612C23 FFC12583 FF812603 FF010693 0066A223 0046A703 08BFA023
08CFA223 08EFA423 FE002823 0000006F
@100
1 1  2 A  3 5  4 C  5 4  6 3
@120
1 8000 00007FFC
2 8004 FFFFFFEF  2 8008 FFFFFFE9  2 800C 00000001  2 8010 00000000
2 8014 FFFFFFEF  2 8018 FFFFFFEF  2 801C 00000000  2 8020 FFFFFF60
2 8024 1FFFFFFD  2 8028 FFFFFFFD
3 802C 00000050  3 8030 FFFFFEC0  3 8034 FFFFFFFB  3 8038 12345000
3 803C 00001080
4 8040 00000100  4 8044 00000201  4 8048 00000102  4 804C 00000203
4 8050 00000104  4 8054 00000205  4 8058 00000106  4 805C 00000207
4 8060 00000108  4 8064 00000209  4 8068 0000010A  4 806C 0000020B
5 8070 00000150  5 8074 00000301  5 8078 00000168  5 807C 00000302
6 8080 FFFFFFEC  6 8084 00000003  6 8088 00000003

// ==== flist.f ====
+incdir+source
source/rv_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/alu.sv
source/cpu_control.sv
source/cpu_top.sv
tests/cpu_tb_sva.sv
tests/cpu_tb.sv
